/* bench/snakeGameTb.sv */
// testbench for the snake game core, checks every plotted pixel frame by frame
`default_nettype none

module snakeGameTb;
    timeunit 1ns;
    timeprecision 1ps;

    import snakePkg::*;

    localparam int TickBits = 12;
    localparam int TickCycles = 1 << TickBits;
    localparam int MoveCount = 10;
    localparam int PixelTimeout = 2 * TickCycles;

    typedef struct packed {
        direction_t key;
        coordX_t headX;
        coordY_t headY;
        score_t score;
        logic [6:0] scoreSegments;
        logic gameOver;
    } move_t;

    logic Clock;
    logic reset;
    logic run;
    logic keyRight;
    logic keyDown;
    logic keyUp;
    logic keyLeft;
    logic [2:0] colorSelect;
    logic plot;
    logic [7:0] pixelX;
    logic [6:0] pixelY;
    logic [2:0] pixelColor;
    logic [3:0] score;
    logic [6:0] scoreSegments;
    logic gameOver;

    move_t moves [MoveCount];
    // reference copy of the segment positions
    coordX_t modelX [SnakeLength];
    coordY_t modelY [SnakeLength];
    logic [2:0] appleIndex;

    snakeGame #(
        .TickBits(TickBits)
    ) snakeGame_inst (
        .Clock(Clock),
        .reset(reset),
        .run(run),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .colorSelect(colorSelect),
        .plot(plot),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor),
        .score(score),
        .scoreSegments(scoreSegments),
        .gameOver(gameOver)
    );

    always #10 Clock = ~Clock;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            failRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // head moves one whole block, coordinates wrap at register width
    function automatic coordX_t movedX(input coordX_t x, input direction_t key);
        if (key == dirRight)
        begin
            return x + coordX_t'(BlockSize);
        end
        else if (key == dirLeft)
        begin
            return x - coordX_t'(BlockSize);
        end
        return x;
    endfunction

    function automatic coordY_t movedY(input coordY_t y, input direction_t key);
        if (key == dirDown)
        begin
            return y + coordY_t'(BlockSize);
        end
        else if (key == dirUp)
        begin
            return y - coordY_t'(BlockSize);
        end
        return y;
    endfunction

    // head block against apple box on both axes
    function automatic logic overlaps(input coordX_t hx, input coordY_t hy,
                                      input coordX_t ax, input coordY_t ay);
        return (int'(hx) < int'(ax) + int'(AppleSize)) && (int'(ax) < int'(hx) + int'(BlockSize))
            && (int'(hy) < int'(ay) + int'(AppleSize)) && (int'(ay) < int'(hy) + int'(BlockSize));
    endfunction

    task automatic waitForPlot(input int limit);
        int waited;
        waited = 0;
        while (plot !== 1'b1)
        begin
            if (waited >= limit)
            begin
                failRun("timed out waiting for the next pixel");
            end
            else
            begin
                @(negedge Clock);
                waited++;
            end
        end
    endtask

    task automatic waitForGameOver(input int limit);
        int waited;
        waited = 0;
        while (gameOver !== 1'b1)
        begin
            if (waited >= limit)
            begin
                failRun("timed out waiting for gameOver after the collision");
            end
            else
            begin
                @(negedge Clock);
                waited++;
            end
        end
    endtask

    task automatic checkQuiet(input int cycles, input string what);
        for (int i = 0; i < cycles; i++)
        begin
            if (plot !== 1'b0)
            begin
                failRun({"a pixel was plotted ", what});
            end
            else
            begin
                @(negedge Clock);
            end
        end
    endtask

    // one block, row major, one pixel per cycle
    task automatic checkBlock(input string what, input coordX_t originX, input coordY_t originY,
                              input blockSize_t size, input color_t color);
        int side;
        coordX_t expX;
        coordY_t expY;
        side = int'(size);
        waitForPlot(PixelTimeout);
        for (int i = 0; i < side * side; i++)
        begin
            expX = originX + coordX_t'(i % side);
            expY = originY + coordY_t'(i / side);
            checkValue({what, " plot"}, 32'(plot), 32'(1'b1));
            checkValue({what, " pixelX"}, 32'(pixelX), 32'(expX));
            checkValue({what, " pixelY"}, 32'(pixelY), 32'(expY));
            checkValue({what, " pixelColor"}, 32'(pixelColor), 32'(color));
            @(negedge Clock);
        end
        checkValue({what, " plot after last pixel"}, 32'(plot), 32'(1'b0));
    endtask

    task automatic pressKey(input direction_t key);
        case (key)
            dirRight: keyRight = 1'b0;
            dirDown: keyDown = 1'b0;
            dirUp: keyUp = 1'b0;
            default: keyLeft = 1'b0;
        endcase
        @(negedge Clock);
        keyRight = 1'b1;
        keyDown = 1'b1;
        keyUp = 1'b1;
        keyLeft = 1'b1;
    endtask

    task automatic loadMoves();
        moves[0] = '{dirLeft, 8'd70, 7'd60, 4'd0, 7'b1000000, 1'b0};
        moves[1] = '{dirLeft, 8'd60, 7'd60, 4'd0, 7'b1000000, 1'b0};
        moves[2] = '{dirLeft, 8'd50, 7'd60, 4'd0, 7'b1000000, 1'b0};
        moves[3] = '{dirLeft, 8'd40, 7'd60, 4'd0, 7'b1000000, 1'b0};
        moves[4] = '{dirLeft, 8'd30, 7'd60, 4'd0, 7'b1000000, 1'b0};
        moves[5] = '{dirUp, 8'd30, 7'd50, 4'd0, 7'b1000000, 1'b0};
        moves[6] = '{dirUp, 8'd30, 7'd40, 4'd0, 7'b1000000, 1'b0};
        // lands on the apple at (30,30)
        moves[7] = '{dirUp, 8'd30, 7'd30, 4'd1, 7'b1111001, 1'b0};
        moves[8] = '{dirRight, 8'd40, 7'd30, 4'd1, 7'b1111001, 1'b0};
        // reverses into segment 1
        moves[9] = '{dirLeft, 8'd30, 7'd30, 4'd1, 7'b1111001, 1'b1};
    endtask

    task automatic playFrame(input move_t m);
        logic modelHit;
        pressKey(m.key);
        for (int k = 0; k < SnakeLength; k++)
        begin
            checkBlock("erase", modelX[k], modelY[k], BlockSize, EraseColor);
        end
        for (int k = SnakeLength - 1; k > 0; k--)
        begin
            modelX[k] = modelX[k-1];
            modelY[k] = modelY[k-1];
        end
        modelX[0] = movedX(modelX[0], m.key);
        modelY[0] = movedY(modelY[0], m.key);
        checkValue("table headX", 32'(m.headX), 32'(modelX[0]));
        checkValue("table headY", 32'(m.headY), 32'(modelY[0]));
        modelHit = 1'b0;
        for (int k = 1; k < SnakeLength; k++)
        begin
            if (modelX[k] == modelX[0] && modelY[k] == modelY[0])
            begin
                modelHit = 1'b1;
            end
        end
        checkValue("table gameOver", 32'(m.gameOver), 32'(modelHit));
        if (modelHit)
        begin
            waitForGameOver(16);
            checkValue("score", 32'(score), 32'(m.score));
            checkQuiet(4 * TickCycles, "after game over");
            checkValue("gameOver", 32'(gameOver), 32'(1'b1));
        end
        else
        begin
            if (overlaps(modelX[0], modelY[0], AppleTableX[appleIndex], AppleTableY[appleIndex]))
            begin
                checkBlock("apple erase", AppleTableX[appleIndex], AppleTableY[appleIndex],
                           AppleSize, EraseColor);
                appleIndex = (appleIndex == 3'(AppleCount - 1)) ? 3'd0 : appleIndex + 3'd1;
            end
            checkBlock("apple", AppleTableX[appleIndex], AppleTableY[appleIndex],
                       AppleSize, AppleColor);
            checkBlock("head", m.headX, m.headY, BlockSize, colorSelect);
            for (int k = 1; k < SnakeLength; k++)
            begin
                checkBlock("segment", modelX[k], modelY[k], BlockSize, colorSelect);
            end
            checkValue("score", 32'(score), 32'(m.score));
            checkValue("scoreSegments", 32'(scoreSegments), 32'(m.scoreSegments));
            checkValue("gameOver", 32'(gameOver), 32'(1'b0));
        end
    endtask

    initial
    begin
        logic [2:0] pick;
        Clock = 1'b0;
        reset = 1'b1;
        run = 1'b0;
        keyRight = 1'b1;
        keyDown = 1'b1;
        keyUp = 1'b1;
        keyLeft = 1'b1;
        void'($urandom(51));
        // nonzero and never the apple colour
        pick = 3'($urandom % 6) + 3'd1;
        if (pick >= AppleColor)
        begin
            pick = pick + 3'd1;
        end
        colorSelect = pick;
        loadMoves();
        appleIndex = 3'd0;
        for (int k = 0; k < SnakeLength; k++)
        begin
            modelX[k] = StartX;
            modelY[k] = StartY + coordY_t'(k * int'(BlockSize));
        end

        repeat (2) @(negedge Clock);
        reset = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            checkValue("plot", 32'(plot), 32'(1'b0));
            checkValue("gameOver", 32'(gameOver), 32'(1'b0));
            checkValue("score", 32'(score), 32'(0));
            checkValue("scoreSegments", 32'(scoreSegments), 32'(7'b1000000));
            @(negedge Clock);
        end

        run = 1'b1;
        checkBlock("first apple", AppleTableX[0], AppleTableY[0], AppleSize, AppleColor);
        for (int k = 0; k < SnakeLength; k++)
        begin
            checkBlock("start segment", modelX[k], modelY[k], BlockSize, colorSelect);
        end
        checkQuiet(3 * TickCycles, "before the first key press");

        for (int r = 0; r < MoveCount; r++)
        begin
            playFrame(moves[r]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/appleKeeper.sv */
// apple keeper that tracks the table entry, detects eating and counts the score
`default_nettype none

module appleKeeper (
    input logic Clock,
    input logic reset,
    input logic relocate,
    input snakePkg::coordX_t headX,
    input snakePkg::coordY_t headY,
    output snakePkg::coordX_t appleX,
    output snakePkg::coordY_t appleY,
    output logic eaten,
    output snakePkg::score_t score
);
    import snakePkg::*;

    logic [2:0] appleIndex;
    logic [8:0] headRight;
    logic [8:0] appleRight;
    logic [7:0] headBottom;
    logic [7:0] appleBottom;
    logic overlapX;
    logic overlapY;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            appleIndex <= '0;
            score <= '0;
        end
        else if (relocate)
        begin
            appleIndex <= (appleIndex == 3'(AppleCount - 1)) ? '0 : appleIndex + 1'b1;
            if (score != ScoreMax)
            begin
                score <= score + 1'b1;
            end
        end
    end

    assign appleX = AppleTableX[appleIndex];
    assign appleY = AppleTableY[appleIndex];

    // box edges one bit wider so the compare does not wrap
    assign headRight = {1'b0, headX} + 9'(BlockSize);
    assign appleRight = {1'b0, appleX} + 9'(AppleSize);
    assign headBottom = {1'b0, headY} + 8'(BlockSize);
    assign appleBottom = {1'b0, appleY} + 8'(AppleSize);

    assign overlapX = ({1'b0, headX} < appleRight) && ({1'b0, appleX} < headRight);
    assign overlapY = ({1'b0, headY} < appleBottom) && ({1'b0, appleY} < headBottom);
    assign eaten = overlapX && overlapY;

    relocateOnlyWhenEaten: assert property (@(posedge Clock) disable iff (reset)
        relocate |-> eaten);

endmodule

`default_nettype wire

/* logic/blockPainter.sv */
// block painter that scans a square block row by row at one pixel per cycle
`default_nettype none

module blockPainter (
    input logic Clock,
    input logic reset,
    paintRequestIf.painter paint,
    output logic plot,
    output snakePkg::coordX_t pixelX,
    output snakePkg::coordY_t pixelY,
    output snakePkg::color_t pixelColor
);
    import snakePkg::*;

    logic busy;
    logic doneReg;
    blockSize_t scanX;
    blockSize_t scanY;
    logic rowEnd;
    logic lastPixel;

    assign rowEnd = (scanX == paint.blockSize - 1'b1);
    assign lastPixel = rowEnd && (scanY == paint.blockSize - 1'b1);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            doneReg <= 1'b0;
            scanX <= '0;
            scanY <= '0;
        end
        else
        begin
            doneReg <= 1'b0;
            if (paint.start)
            begin
                busy <= 1'b1;
                scanX <= '0;
                scanY <= '0;
            end
            else if (busy)
            begin
                if (lastPixel)
                begin
                    busy <= 1'b0;
                    doneReg <= 1'b1;
                end
                else if (rowEnd)
                begin
                    scanX <= '0;
                    scanY <= scanY + 1'b1;
                end
                else
                begin
                    scanX <= scanX + 1'b1;
                end
            end
        end
    end

    // pixel comes straight from the scan position
    assign plot = busy;
    assign pixelX = paint.originX + coordX_t'(scanX);
    assign pixelY = paint.originY + coordY_t'(scanY);
    assign pixelColor = paint.color;
    assign paint.done = doneReg;

    // controller must wait for done before a new request
    startWhileBusy: assert property (@(posedge Clock) disable iff (reset)
        paint.start |-> !busy);

endmodule

`default_nettype wire

/* logic/gameController.sv */
// game controller with the frame tick divider and the draw, erase and move sequencing
`default_nettype none

module gameController #(
    parameter int TickBits = 20
) (
    input logic Clock,
    input logic reset,
    input logic run,
    input snakePkg::color_t colorSelect,
    paintRequestIf.controller paint,
    output logic [2:0] segmentIndex,
    input snakePkg::coordX_t segmentX,
    input snakePkg::coordY_t segmentY,
    input snakePkg::coordX_t appleX,
    input snakePkg::coordY_t appleY,
    input logic hit,
    input logic eaten,
    input logic directionSet,
    output logic step,
    output logic relocate,
    output logic gameOver
);
    import snakePkg::*;

    gameState_t state;
    logic [TickBits-1:0] tickCount;
    logic tick;
    logic [2:0] segCount;
    logic lastSegment;
    logic launched;
    logic paintState;
    logic applePaint;

    // free running frame divider
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            tickCount <= '0;
        end
        else
        begin
            tickCount <= tickCount + 1'b1;
        end
    end

    assign tick = (tickCount == '0);
    assign lastSegment = (segCount == 3'(SnakeLength - 1));

    assign paintState = (state inside {stDrawApple, stDrawSegment, stErase, stEraseApple});
    assign applePaint = (state == stDrawApple) || (state == stEraseApple);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= stIdle;
            segCount <= '0;
            launched <= 1'b0;
        end
        else
        begin
            // one request per paint state, cleared by done
            if (paint.start)
            begin
                launched <= 1'b1;
            end
            else if (paint.done)
            begin
                launched <= 1'b0;
            end

            case (state)
                stIdle:
                begin
                    if (run)
                    begin
                        state <= stDrawApple;
                    end
                end
                stDrawApple:
                begin
                    if (paint.done)
                    begin
                        segCount <= '0;
                        state <= stDrawSegment;
                    end
                end
                stDrawSegment:
                begin
                    if (paint.done)
                    begin
                        if (lastSegment)
                        begin
                            state <= stWaitKey;
                        end
                        else
                        begin
                            segCount <= segCount + 1'b1;
                        end
                    end
                end
                // passes straight through once a key is latched
                stWaitKey:
                begin
                    if (directionSet)
                    begin
                        state <= stWaitTick;
                    end
                end
                stWaitTick:
                begin
                    if (tick)
                    begin
                        segCount <= '0;
                        state <= stErase;
                    end
                end
                stErase:
                begin
                    if (paint.done)
                    begin
                        if (lastSegment)
                        begin
                            state <= stStep;
                        end
                        else
                        begin
                            segCount <= segCount + 1'b1;
                        end
                    end
                end
                stStep:
                begin
                    state <= stCheck;
                end
                // body has moved, hit and eaten now refer to the new head
                stCheck:
                begin
                    if (hit)
                    begin
                        state <= stGameOver;
                    end
                    else if (eaten)
                    begin
                        state <= stEraseApple;
                    end
                    else
                    begin
                        state <= stDrawApple;
                    end
                end
                stEraseApple:
                begin
                    if (paint.done)
                    begin
                        state <= stRelocate;
                    end
                end
                stRelocate:
                begin
                    state <= stDrawApple;
                end
                stGameOver:
                begin
                    state <= stGameOver;
                end
                default:
                begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // request fields stay put because state and segCount hold during a paint
    assign paint.start = paintState && !launched;
    assign paint.originX = applePaint ? appleX : segmentX;
    assign paint.originY = applePaint ? appleY : segmentY;
    assign paint.blockSize = applePaint ? AppleSize : BlockSize;

    always_comb
    begin
        case (state)
            stDrawApple: paint.color = AppleColor;
            stDrawSegment: paint.color = colorSelect;
            default: paint.color = EraseColor;
        endcase
    end

    assign segmentIndex = segCount;
    assign step = (state == stStep);
    assign relocate = (state == stRelocate);
    assign gameOver = (state == stGameOver);

endmodule

`default_nettype wire

/* logic/paintRequestIf.sv */
// block paint request channel from the game controller to the block painter
`default_nettype none

interface paintRequestIf;
    import snakePkg::*;

    logic start;
    coordX_t originX;
    coordY_t originY;
    blockSize_t blockSize;
    color_t color;
    logic done;

    // controller holds origin, size and colour until done
    modport controller (output start, originX, originY, blockSize, color, input done);

    modport painter (input start, originX, originY, blockSize, color, output done);

endinterface

`default_nettype wire

/* logic/scoreDecoder.sv */
// score digit to active-low seven-segment decoder
`default_nettype none

module scoreDecoder (
    input snakePkg::score_t score,
    output logic [6:0] segments
);
    import snakePkg::*;

    // bit 0 is the top segment, bit 6 the middle one
    always_comb
    begin
        case (score)
            score_t'(0): segments = 7'b1000000;
            score_t'(1): segments = 7'b1111001;
            score_t'(2): segments = 7'b0100100;
            score_t'(3): segments = 7'b0110000;
            score_t'(4): segments = 7'b0011001;
            score_t'(5): segments = 7'b0010010;
            score_t'(6): segments = 7'b0000010;
            score_t'(7): segments = 7'b1111000;
            score_t'(8): segments = 7'b0000000;
            score_t'(9): segments = 7'b0011000;
            default: segments = 7'b1111111;
        endcase
    end

endmodule

`default_nettype wire

/* logic/snakeBody.sv */
// snake body with key direction latch, segment shift register and self collision check
`default_nettype none

module snakeBody (
    input logic Clock,
    input logic reset,
    input logic step,
    input logic keyRight,
    input logic keyDown,
    input logic keyUp,
    input logic keyLeft,
    input logic [2:0] segmentIndex,
    output snakePkg::coordX_t segmentX,
    output snakePkg::coordY_t segmentY,
    output snakePkg::coordX_t headX,
    output snakePkg::coordY_t headY,
    output logic hit,
    output logic directionSet
);
    import snakePkg::*;

    direction_t direction;
    coordX_t bodyX [SnakeLength];
    coordY_t bodyY [SnakeLength];
    coordX_t nextX;
    coordY_t nextY;

    // keys are active low, right has priority
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            direction <= dirNone;
        end
        else if (!keyRight)
        begin
            direction <= dirRight;
        end
        else if (!keyDown)
        begin
            direction <= dirDown;
        end
        else if (!keyUp)
        begin
            direction <= dirUp;
        end
        else if (!keyLeft)
        begin
            direction <= dirLeft;
        end
    end

    // head moves a whole block, coordinates wrap
    always_comb
    begin
        nextX = bodyX[0];
        nextY = bodyY[0];
        case (direction)
            dirRight: nextX = bodyX[0] + coordX_t'(BlockSize);
            dirLeft: nextX = bodyX[0] - coordX_t'(BlockSize);
            dirDown: nextY = bodyY[0] + coordY_t'(BlockSize);
            dirUp: nextY = bodyY[0] - coordY_t'(BlockSize);
            default: ;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // vertical column with the head on top
            for (int k = 0; k < SnakeLength; k++)
            begin
                bodyX[k] <= StartX;
                bodyY[k] <= StartY + coordY_t'(k * BlockSize);
            end
        end
        else if (step)
        begin
            for (int k = 1; k < SnakeLength; k++)
            begin
                bodyX[k] <= bodyX[k-1];
                bodyY[k] <= bodyY[k-1];
            end
            bodyX[0] <= nextX;
            bodyY[0] <= nextY;
        end
    end

    // head on any body segment, segment 1 included
    always_comb
    begin
        hit = 1'b0;
        for (int k = 1; k < SnakeLength; k++)
        begin
            if (bodyX[0] == bodyX[k] && bodyY[0] == bodyY[k])
            begin
                hit = 1'b1;
            end
        end
    end

    assign segmentX = (segmentIndex < 3'(SnakeLength)) ? bodyX[segmentIndex] : '0;
    assign segmentY = (segmentIndex < 3'(SnakeLength)) ? bodyY[segmentIndex] : '0;
    assign headX = bodyX[0];
    assign headY = bodyY[0];
    assign directionSet = (direction != dirNone);

    // the controller only steps once a key has been seen
    stepNeedsDirection: assert property (@(posedge Clock) disable iff (reset)
        step |-> direction != dirNone);

endmodule

`default_nettype wire

/* logic/snakeGame.sv */
// snake game core that streams block pixels to an external framebuffer
`default_nettype none

module snakeGame #(
    parameter int TickBits = 20
) (
    input logic Clock,
    input logic reset,
    input logic run,
    input logic keyRight,
    input logic keyDown,
    input logic keyUp,
    input logic keyLeft,
    input logic [2:0] colorSelect,
    output logic plot,
    output logic [7:0] pixelX,
    output logic [6:0] pixelY,
    output logic [2:0] pixelColor,
    output logic [3:0] score,
    output logic [6:0] scoreSegments,
    output logic gameOver
);
    import snakePkg::*;

    paintRequestIf paintBus ();

    logic [2:0] segmentIndex;
    coordX_t segmentX;
    coordY_t segmentY;
    coordX_t headX;
    coordY_t headY;
    coordX_t appleX;
    coordY_t appleY;
    logic hit;
    logic eaten;
    logic directionSet;
    logic step;
    logic relocate;

    blockPainter blockPainter_inst (
        .Clock(Clock),
        .reset(reset),
        .paint(paintBus.painter),
        .plot(plot),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor)
    );

    snakeBody snakeBody_inst (
        .Clock(Clock),
        .reset(reset),
        .step(step),
        .keyRight(keyRight),
        .keyDown(keyDown),
        .keyUp(keyUp),
        .keyLeft(keyLeft),
        .segmentIndex(segmentIndex),
        .segmentX(segmentX),
        .segmentY(segmentY),
        .headX(headX),
        .headY(headY),
        .hit(hit),
        .directionSet(directionSet)
    );

    appleKeeper appleKeeper_inst (
        .Clock(Clock),
        .reset(reset),
        .relocate(relocate),
        .headX(headX),
        .headY(headY),
        .appleX(appleX),
        .appleY(appleY),
        .eaten(eaten),
        .score(score)
    );

    scoreDecoder scoreDecoder_inst (
        .score(score),
        .segments(scoreSegments)
    );

    gameController #(
        .TickBits(TickBits)
    ) gameController_inst (
        .Clock(Clock),
        .reset(reset),
        .run(run),
        .colorSelect(colorSelect),
        .paint(paintBus.controller),
        .segmentIndex(segmentIndex),
        .segmentX(segmentX),
        .segmentY(segmentY),
        .appleX(appleX),
        .appleY(appleY),
        .hit(hit),
        .eaten(eaten),
        .directionSet(directionSet),
        .step(step),
        .relocate(relocate),
        .gameOver(gameOver)
    );

endmodule

`default_nettype wire

/* logic/snakePkg.sv */
// snake game package with the shared types, fixed sizes and apple relocation table
`default_nettype none

package snakePkg;

    // pixel framebuffer is 160 x 120
    typedef logic [7:0] coordX_t;
    typedef logic [6:0] coordY_t;
    typedef logic [2:0] color_t;
    typedef logic [3:0] score_t;
    typedef logic [3:0] blockSize_t;

    typedef enum logic [2:0] {
        dirNone,
        dirRight,
        dirDown,
        dirUp,
        dirLeft
    } direction_t;

    typedef enum logic [3:0] {
        stIdle,
        stDrawApple,
        stDrawSegment,
        stWaitKey,
        stWaitTick,
        stErase,
        stStep,
        stCheck,
        stEraseApple,
        stRelocate,
        stGameOver
    } gameState_t;

    localparam int SnakeLength = 6;
    localparam blockSize_t BlockSize = 4'd10;
    localparam blockSize_t AppleSize = 4'd4;

    // segment k starts at StartY + k * BlockSize, head on top
    localparam coordX_t StartX = 8'd80;
    localparam coordY_t StartY = 7'd60;

    localparam int AppleCount = 7;
    localparam coordX_t AppleTableX [AppleCount] = '{8'd30, 8'd10, 8'd70, 8'd60, 8'd20, 8'd50, 8'd80};
    localparam coordY_t AppleTableY [AppleCount] = '{7'd30, 7'd20, 7'd40, 7'd100, 7'd80, 7'd10, 7'd50};

    localparam color_t AppleColor = 3'd4;
    localparam color_t EraseColor = 3'd0;
    localparam score_t ScoreMax = 4'd9;

endpackage

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# compile with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module snakeGameTb -Mdir obj_dir \
    -o snakeGameSim -f snakeGame.f || { echo "build failed"; exit 1; }
./obj_dir/snakeGameSim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

/* snakeGame.f */
logic/snakePkg.sv
logic/paintRequestIf.sv
logic/blockPainter.sv
logic/snakeBody.sv
logic/appleKeeper.sv
logic/scoreDecoder.sv
logic/gameController.sv
logic/snakeGame.sv
bench/snakeGameTb.sv
